// File: hdl/subsys_pkg.sv
////////////////////
// subsystem package
// instruction encoding, peripheral map and the bus and offload
// payload structs shared by the core, RAM and coprocessor
////////////////////

package subsys_pkg;

  // accumulator core opcodes, any other code executes as a nop
  typedef enum logic [3:0] {
    OP_NOP  = 4'h0,
    OP_LDI  = 4'h1,
    OP_ADDI = 4'h2,
    OP_LD   = 4'h3,
    OP_ST   = 4'h4,
    OP_MUL  = 4'h5
  } opcode_e;

  typedef struct packed {
    opcode_e     opcode;
    logic [11:0] imm;
  } instr_t;

  // word addresses from here up belong to the peripheral registers
  localparam logic [11:0] PERIPH_BASE = 12'hF00;
  localparam logic [11:0] PASS_ADDR   = 12'hF00;
  localparam logic [11:0] EXIT_ADDR   = 12'hF04;

  typedef struct packed {
    logic [11:0] addr;
    logic        we;
    logic [31:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic [11:0] addr;
    logic [31:0] data;
  } load_req_t;

  typedef struct packed {
    logic [31:0] op_a;
    logic [31:0] op_b;
  } x_req_t;

  typedef struct packed {
    logic [31:0] product;
  } x_rsp_t;

endpackage

// File: hdl/acc_core.sv
////////////////////
// accumulator core
// fetches 16-bit instructions, runs them against a 32-bit
// accumulator, reaches memory on the data bus and hands
// multiplies to the offload coprocessor
////////////////////

module acc_core #(
  parameter int unsigned RAM_ADDR_WIDTH = 8,
  parameter logic [11:0] BOOT_ADDR      = 12'h000
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 fetch_enable_i,
  input  logic                 done_i,

  output logic                 instr_req_o,
  output subsys_pkg::mem_req_t instr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  subsys_pkg::mem_rsp_t instr_rsp_i,

  output logic                 data_req_o,
  output subsys_pkg::mem_req_t data_o,
  input  logic                 data_gnt_i,
  input  logic                 data_rvalid_i,
  input  subsys_pkg::mem_rsp_t data_rsp_i,

  output logic                 x_valid_o,
  output subsys_pkg::x_req_t   x_req_o,
  input  logic                 x_ready_i,
  input  logic                 x_rvalid_i,
  input  subsys_pkg::x_rsp_t   x_rsp_i,
  output logic                 x_rready_o
);

  import subsys_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH,
    S_WAIT_INSTR,
    S_EXECUTE,
    S_WAIT_DATA,
    S_OFF_SEND,
    S_OFF_WAIT
  } state_e;

  // program counter wraps at the RAM depth
  localparam logic [11:0] PC_MASK = 12'((1 << RAM_ADDR_WIDTH) - 1);

  state_e      state_q;
  logic [11:0] pc_q;
  logic [31:0] acc_q;
  instr_t      instr_q;
  logic [31:0] opnd_q;
  logic        data_sent_q;

  logic [11:0] pc_next;
  logic        run_on;
  logic        is_mem_op;
  logic        retire;

  assign pc_next   = (pc_q + 12'd1) & PC_MASK;
  assign run_on    = fetch_enable_i & ~done_i;
  assign is_mem_op = (instr_q.opcode == OP_LD) || (instr_q.opcode == OP_ST) ||
                     (instr_q.opcode == OP_MUL);

  // one instruction finishes per retire pulse
  assign retire = ((state_q == S_EXECUTE) && !is_mem_op) ||
                  ((state_q == S_WAIT_DATA) && data_rvalid_i && (instr_q.opcode != OP_MUL)) ||
                  ((state_q == S_OFF_WAIT) && x_rvalid_i);

  assign instr_req_o = (state_q == S_FETCH);
  assign instr_o     = '{addr: pc_q, we: 1'b0, wdata: 32'h0};

  // data request stays up until its grant, then the core waits for rvalid
  assign data_req_o = (state_q == S_WAIT_DATA) && !data_sent_q;
  assign data_o     = '{addr: instr_q.imm, we: (instr_q.opcode == OP_ST), wdata: acc_q};

  assign x_valid_o  = (state_q == S_OFF_SEND);
  assign x_req_o    = '{op_a: acc_q, op_b: opnd_q};
  assign x_rready_o = (state_q == S_OFF_WAIT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= S_IDLE;
      pc_q        <= BOOT_ADDR;
      acc_q       <= 32'h0;
      data_sent_q <= 1'b0;
    end else begin
      unique case (state_q)
        S_IDLE: begin
          if (run_on) begin
            state_q <= S_FETCH;
          end
        end
        S_FETCH: begin
          if (instr_gnt_i) begin
            state_q <= S_WAIT_INSTR;
          end
        end
        S_WAIT_INSTR: begin
          if (instr_rvalid_i) begin
            instr_q <= instr_t'(instr_rsp_i.rdata[15:0]);
            state_q <= S_EXECUTE;
          end
        end
        S_EXECUTE: begin
          case (instr_q.opcode)
            OP_LDI:  acc_q <= {20'h0, instr_q.imm};
            OP_ADDI: acc_q <= acc_q + {20'h0, instr_q.imm};
            OP_LD, OP_ST, OP_MUL: begin
              data_sent_q <= 1'b0;
              state_q     <= S_WAIT_DATA;
            end
            default: ;
          endcase
        end
        S_WAIT_DATA: begin
          if (data_req_o && data_gnt_i) begin
            data_sent_q <= 1'b1;
          end
          if (data_rvalid_i) begin
            if (instr_q.opcode == OP_LD) begin
              acc_q <= data_rsp_i.rdata;
            end else if (instr_q.opcode == OP_MUL) begin
              // memory operand is in, now offload the multiply
              opnd_q  <= data_rsp_i.rdata;
              state_q <= S_OFF_SEND;
            end
          end
        end
        S_OFF_SEND: begin
          if (x_ready_i) begin
            state_q <= S_OFF_WAIT;
          end
        end
        S_OFF_WAIT: begin
          if (x_rvalid_i) begin
            acc_q <= x_rsp_i.product;
          end
        end
        default: state_q <= S_IDLE;
      endcase

      // stop here once the run has ended or fetch is disabled
      if (retire) begin
        pc_q    <= pc_next;
        state_q <= run_on ? S_FETCH : S_IDLE;
      end
    end
  end

endmodule

// File: hdl/mul_copro.sv
////////////////////
// multiply coprocessor
// two-stage offload pipeline returning the low 32 bits
// of the product, stalls under response back-pressure
////////////////////

module mul_copro (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               x_valid_i,
  input  subsys_pkg::x_req_t x_req_i,
  output logic               x_ready_o,
  output logic               x_rvalid_o,
  output subsys_pkg::x_rsp_t x_rsp_o,
  input  logic               x_rready_i
);

  logic        s1_valid_q;
  logic [31:0] s1_a_q;
  logic [31:0] s1_b_q;
  logic        s2_valid_q;
  logic [31:0] s2_prod_q;

  logic        s1_ready;
  logic        s2_ready;

  // a stage can advance when it is empty or the next one moves
  assign s2_ready = !s2_valid_q || x_rready_i;
  assign s1_ready = !s1_valid_q || s2_ready;

  assign x_ready_o  = s1_ready;
  assign x_rvalid_o = s2_valid_q;
  assign x_rsp_o    = '{product: s2_prod_q};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= x_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (s1_ready && x_valid_i) begin
      s1_a_q <= x_req_i.op_a;
      s1_b_q <= x_req_i.op_b;
    end
    // 32-bit context keeps only the low word of the product
    if (s2_ready && s1_valid_q) begin
      s2_prod_q <= s1_a_q * s1_b_q;
    end
  end

endmodule

// File: hdl/mm_ram.sv
////////////////////
// memory-mapped RAM
// word array with instruction and data read ports, a shared
// write port for the loader and data bus, and the decode
// of the peripheral region
////////////////////

module mm_ram #(
  parameter int unsigned RAM_ADDR_WIDTH = 8
) (
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  instr_req_i,
  input  subsys_pkg::mem_req_t  instr_i,
  output logic                  instr_gnt_o,
  output logic                  instr_rvalid_o,
  output subsys_pkg::mem_rsp_t  instr_rsp_o,

  input  logic                  data_req_i,
  input  subsys_pkg::mem_req_t  data_i,
  output logic                  data_gnt_o,
  output logic                  data_rvalid_o,
  output subsys_pkg::mem_rsp_t  data_rsp_o,

  input  logic                  load_valid_i,
  input  subsys_pkg::load_req_t load_i,

  output logic                  periph_we_o,
  output logic [11:0]           periph_addr_o,
  output logic [31:0]           periph_wdata_o
);

  import subsys_pkg::*;

  localparam int unsigned DEPTH = 2 ** RAM_ADDR_WIDTH;

  logic [31:0] mem_q [DEPTH];

  logic        instr_rvalid_q;
  logic        data_rvalid_q;
  mem_rsp_t    instr_rsp_q;
  mem_rsp_t    data_rsp_q;
  logic        is_periph;

  assign is_periph = (data_i.addr >= PERIPH_BASE);

  // both ports grant in the request cycle
  assign instr_gnt_o = instr_req_i;
  assign data_gnt_o  = data_req_i;

  assign instr_rvalid_o = instr_rvalid_q;
  assign instr_rsp_o    = instr_rsp_q;
  assign data_rvalid_o  = data_rvalid_q;
  assign data_rsp_o     = data_rsp_q;

  assign periph_we_o    = data_gnt_o && data_i.we && is_periph;
  assign periph_addr_o  = data_i.addr;
  assign periph_wdata_o = data_i.wdata;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      instr_rvalid_q <= 1'b0;
      data_rvalid_q  <= 1'b0;
    end else begin
      instr_rvalid_q <= instr_gnt_o;
      data_rvalid_q  <= data_gnt_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_gnt_o) begin
      instr_rsp_q.rdata <= mem_q[instr_i.addr[RAM_ADDR_WIDTH-1:0]];
    end
    // peripheral reads come back as zero
    if (data_gnt_o && !data_i.we) begin
      data_rsp_q.rdata <= is_periph ? 32'h0 : mem_q[data_i.addr[RAM_ADDR_WIDTH-1:0]];
    end
    // loader takes the write port ahead of the core
    if (load_valid_i) begin
      mem_q[load_i.addr[RAM_ADDR_WIDTH-1:0]] <= load_i.data;
    end else if (data_gnt_o && data_i.we && !is_periph) begin
      mem_q[data_i.addr[RAM_ADDR_WIDTH-1:0]] <= data_i.wdata;
    end
  end

endmodule

// File: hdl/exit_regs.sv
////////////////////
// exit registers
// peripheral block that records the pass flag or the
// exit value, first ending write wins
////////////////////

module exit_regs (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        periph_we_i,
  input  logic [11:0] periph_addr_i,
  input  logic [31:0] periph_wdata_i,
  output logic        tests_passed_o,
  output logic        tests_failed_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,
  output logic        done_o
);

  import subsys_pkg::*;

  logic        passed_q;
  logic        failed_q;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;
  assign exit_valid_o   = exit_valid_q;
  assign exit_value_o   = exit_value_q;
  assign done_o         = passed_q | exit_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      passed_q     <= 1'b0;
      failed_q     <= 1'b0;
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
    end else if (periph_we_i && !done_o) begin
      if (periph_addr_i == PASS_ADDR) begin
        passed_q <= 1'b1;
      end else if (periph_addr_i == EXIT_ADDR) begin
        exit_value_q <= periph_wdata_i;
        exit_valid_q <= 1'b1;
        failed_q     <= (periph_wdata_i != 32'h0);
      end
    end
  end

endmodule

// File: hdl/tb_subsystem.sv
////////////////////
// test subsystem top
// accumulator core with its multiply coprocessor,
// memory-mapped RAM and exit registers
////////////////////

module tb_subsystem #(
  parameter int unsigned RAM_ADDR_WIDTH = 8,
  parameter logic [11:0] BOOT_ADDR      = 12'h000
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  fetch_enable_i,
  input  logic                  load_valid_i,
  input  subsys_pkg::load_req_t load_i,
  output logic                  tests_passed_o,
  output logic                  tests_failed_o,
  output logic                  exit_valid_o,
  output logic [31:0]           exit_value_o
);

  import subsys_pkg::*;

  // core to memory
  logic        instr_req;
  mem_req_t    instr_addr;
  logic        instr_gnt;
  logic        instr_rvalid;
  mem_rsp_t    instr_rsp;
  logic        data_req;
  mem_req_t    data_ctrl;
  logic        data_gnt;
  logic        data_rvalid;
  mem_rsp_t    data_rsp;

  // offload channels
  logic        x_valid;
  x_req_t      x_req;
  logic        x_ready;
  logic        x_rvalid;
  x_rsp_t      x_rsp;
  logic        x_rready;

  // peripheral path
  logic        periph_we;
  logic [11:0] periph_addr;
  logic [31:0] periph_wdata;
  logic        done;

  acc_core #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
    .BOOT_ADDR     (BOOT_ADDR)
  ) core_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_enable_i(fetch_enable_i),
    .done_i        (done),
    .instr_req_o   (instr_req),
    .instr_o       (instr_addr),
    .instr_gnt_i   (instr_gnt),
    .instr_rvalid_i(instr_rvalid),
    .instr_rsp_i   (instr_rsp),
    .data_req_o    (data_req),
    .data_o        (data_ctrl),
    .data_gnt_i    (data_gnt),
    .data_rvalid_i (data_rvalid),
    .data_rsp_i    (data_rsp),
    .x_valid_o     (x_valid),
    .x_req_o       (x_req),
    .x_ready_i     (x_ready),
    .x_rvalid_i    (x_rvalid),
    .x_rsp_i       (x_rsp),
    .x_rready_o    (x_rready)
  );

  mul_copro copro_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .x_valid_i (x_valid),
    .x_req_i   (x_req),
    .x_ready_o (x_ready),
    .x_rvalid_o(x_rvalid),
    .x_rsp_o   (x_rsp),
    .x_rready_i(x_rready)
  );

  mm_ram #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
  ) ram_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_req_i   (instr_req),
    .instr_i       (instr_addr),
    .instr_gnt_o   (instr_gnt),
    .instr_rvalid_o(instr_rvalid),
    .instr_rsp_o   (instr_rsp),
    .data_req_i    (data_req),
    .data_i        (data_ctrl),
    .data_gnt_o    (data_gnt),
    .data_rvalid_o (data_rvalid),
    .data_rsp_o    (data_rsp),
    .load_valid_i  (load_valid_i),
    .load_i        (load_i),
    .periph_we_o   (periph_we),
    .periph_addr_o (periph_addr),
    .periph_wdata_o(periph_wdata)
  );

  exit_regs exit_regs_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .periph_we_i   (periph_we),
    .periph_addr_i (periph_addr),
    .periph_wdata_i(periph_wdata),
    .tests_passed_o(tests_passed_o),
    .tests_failed_o(tests_failed_o),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .done_o        (done)
  );

endmodule

// File: sim/clk_gen.sv
////////////////////
// testbench clock
// free-running clock source
////////////////////

module clk_gen #(
  parameter int unsigned PERIOD = 8
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// File: sim/tb_asserts.sv
////////////////////
// handshake assertions
// bus grant to response timing and offload channel
// stability, bound into the core and the coprocessor
////////////////////

module tb_asserts #(
  parameter bit BUS_CHECKS = 1'b1
) (
  input logic               clk_i,
  input logic               reset_i,
  input logic               instr_req_i,
  input logic               instr_gnt_i,
  input logic               instr_rvalid_i,
  input logic               data_req_i,
  input logic               data_gnt_i,
  input logic               data_rvalid_i,
  input logic               x_valid_i,
  input logic               x_ready_i,
  input subsys_pkg::x_req_t x_req_i,
  input logic               x_rvalid_i,
  input logic               x_rready_i
);

  // a stalled offload request keeps valid and its operands
  x_req_stable: assert property (@(posedge clk_i) disable iff (reset_i)
    x_valid_i && !x_ready_i |=> x_valid_i && $stable(x_req_i))
    else $error("offload request dropped or changed before ready");

  x_rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    x_rvalid_i && !x_rready_i |=> x_rvalid_i)
    else $error("offload response dropped before rready");

  // memory buses exist only on the core side
  if (BUS_CHECKS) begin : g_bus
    // response valid exactly one cycle after each grant
    instr_rvalid_timing: assert property (@(posedge clk_i) disable iff (reset_i)
      instr_rvalid_i == $past(instr_req_i && instr_gnt_i))
      else $error("instruction rvalid not one cycle after grant");

    data_rvalid_timing: assert property (@(posedge clk_i) disable iff (reset_i)
      data_rvalid_i == $past(data_req_i && data_gnt_i))
      else $error("data rvalid not one cycle after grant");
  end

endmodule

bind acc_core tb_asserts core_asserts (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .instr_req_i   (instr_req_o),
  .instr_gnt_i   (instr_gnt_i),
  .instr_rvalid_i(instr_rvalid_i),
  .data_req_i    (data_req_o),
  .data_gnt_i    (data_gnt_i),
  .data_rvalid_i (data_rvalid_i),
  .x_valid_i     (x_valid_o),
  .x_ready_i     (x_ready_i),
  .x_req_i       (x_req_o),
  .x_rvalid_i    (x_rvalid_i),
  .x_rready_i    (x_rready_o)
);

// the coprocessor only sees the offload channels
bind mul_copro tb_asserts #(
  .BUS_CHECKS(1'b0)
) copro_asserts (
  .clk_i         (clk_i),
  .reset_i       (reset_i),
  .instr_req_i   (1'b0),
  .instr_gnt_i   (1'b0),
  .instr_rvalid_i(1'b0),
  .data_req_i    (1'b0),
  .data_gnt_i    (1'b0),
  .data_rvalid_i (1'b0),
  .x_valid_i     (x_valid_i),
  .x_ready_i     (x_ready_o),
  .x_req_i       (x_req_i),
  .x_rvalid_i    (x_rvalid_o),
  .x_rready_i    (x_rready_i)
);

// File: sim/tb_top.sv
////////////////////
// subsystem testbench
// builds straight-line programs, loads them with a data
// area, runs the core and checks the exit state and data
// memory against an instruction-level model
////////////////////

module tb_top;

  import subsys_pkg::*;

  localparam int unsigned RAM_ADDR_WIDTH = 8;
  localparam logic [11:0] BOOT_ADDR      = 12'h000;
  localparam int unsigned NUM_TESTS      = 20;
  localparam int unsigned DATA_BASE      = 128;
  localparam int unsigned DATA_WORDS     = 64;
  localparam int unsigned MAX_INSTRS     = 32;
  localparam int unsigned SETTLE_CYCLES  = 16;
  // reset, program and data load, and the settle time after a run
  localparam int unsigned LOAD_CYCLES    = 8 + MAX_INSTRS + DATA_WORDS + 40;
  localparam int unsigned CYCLE_LIMIT    = NUM_TESTS * (MAX_INSTRS * 12 + LOAD_CYCLES);

  logic        clk;
  logic        reset;
  logic        fetch_enable;
  logic        load_valid;
  load_req_t   load_req;
  logic        tests_passed;
  logic        tests_failed;
  logic        exit_valid;
  logic [31:0] exit_value;

  logic [15:0] prog [$];
  logic [31:0] ref_mem [2 ** RAM_ADDR_WIDTH];
  logic        exp_passed;
  logic        exp_exited;
  logic [31:0] exp_value;
  int unsigned cur_test;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned cycles = 0;
  event        run_go;
  event        run_checked;

  clk_gen #(.PERIOD(8)) clk_gen_i (.clk_o(clk));

  tb_subsystem #(
    .RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
    .BOOT_ADDR     (BOOT_ADDR)
  ) DUT (
    .clk_i         (clk),
    .reset_i       (reset),
    .fetch_enable_i(fetch_enable),
    .load_valid_i  (load_valid),
    .load_i        (load_req),
    .tests_passed_o(tests_passed),
    .tests_failed_o(tests_failed),
    .exit_valid_o  (exit_valid),
    .exit_value_o  (exit_value)
  );

  // executes prog on ref_mem up to the first ending store
  function automatic void run_model(output logic passed, output logic exited,
                                    output logic [31:0] value);
    logic [31:0] acc;
    logic [3:0]  op;
    logic [11:0] imm;
    logic [31:0] word;
    acc    = 32'h0;
    passed = 1'b0;
    exited = 1'b0;
    value  = 32'h0;
    foreach (prog[i]) begin
      if (passed || exited) begin
        break;
      end
      op   = prog[i][15:12];
      imm  = prog[i][11:0];
      word = (imm >= PERIPH_BASE) ? 32'h0 : ref_mem[imm[RAM_ADDR_WIDTH-1:0]];
      case (op)
        OP_LDI:  acc = {20'h0, imm};
        OP_ADDI: acc = acc + {20'h0, imm};
        OP_LD:   acc = word;
        OP_MUL:  acc = acc * word;
        OP_ST: begin
          if (imm == PASS_ADDR) begin
            passed = 1'b1;
          end else if (imm == EXIT_ADDR) begin
            exited = 1'b1;
            value  = acc;
          end else if (imm < PERIPH_BASE) begin
            ref_mem[imm[RAM_ADDR_WIDTH-1:0]] = acc;
          end
        end
        default: ;
      endcase
    end
  endfunction

  function automatic void append_instr(opcode_e op, logic [11:0] imm);
    prog.push_back({op, imm});
  endfunction

  function automatic logic [11:0] data_addr();
    return 12'(DATA_BASE + $urandom_range(0, DATA_WORDS - 1));
  endfunction

  function automatic void append_random_mix(int unsigned count);
    logic [11:0] imm;
    for (int unsigned i = 0; i < count; i++) begin
      imm = 12'($urandom);
      case ($urandom_range(0, 5))
        0: append_instr(OP_LDI, imm);
        1: append_instr(OP_ADDI, imm);
        2: append_instr(OP_LD, data_addr());
        3: append_instr(OP_ST, data_addr());
        4: append_instr(OP_NOP, imm);
        // unused opcodes behave as nop
        default: prog.push_back({4'($urandom_range(6, 15)), imm});
      endcase
    end
  endfunction

  task automatic build_test(int unsigned idx);
    logic [11:0] addr;
    prog.delete();
    for (int i = 0; i < DATA_WORDS; i++) begin
      ref_mem[DATA_BASE + i] = $urandom;
    end
    if (idx < 8) begin
      append_random_mix($urandom_range(10, 28));
      // one run exits with zero so the fail flag stays low
      if (idx == 3) begin
        append_instr(OP_LDI, 12'h0);
      end
      append_instr(OP_ST, EXIT_ADDR);
    end else if (idx < 12) begin
      // full 32-bit words as operands, products overflow
      append_instr(OP_LD, data_addr());
      repeat (6) begin
        append_instr(OP_MUL, data_addr());
        append_instr(OP_ADDI, 12'($urandom));
      end
      append_instr(OP_ST, EXIT_ADDR);
    end else if (idx < 15) begin
      addr = data_addr();
      append_instr(OP_LDI, 12'($urandom));
      append_instr(OP_ADDI, 12'($urandom));
      append_instr(OP_ST, addr);
      append_instr(OP_LDI, 12'h0);
      append_instr(OP_NOP, 12'h0);
      append_instr(OP_LD, addr);
      append_instr(OP_ST, EXIT_ADDR);
    end else if (idx < 17) begin
      append_random_mix($urandom_range(5, 20));
      append_instr(OP_ST, PASS_ADDR);
    end else begin
      // stores after the first ending store must have no effect
      append_random_mix($urandom_range(5, 20));
      append_instr(OP_ST, EXIT_ADDR);
      append_instr(OP_LDI, 12'($urandom));
      append_instr(OP_ST, EXIT_ADDR);
      append_instr(OP_ST, PASS_ADDR);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset        = 1'b1;
    fetch_enable = 1'b0;
    repeat (8) @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic load_memory();
    foreach (prog[i]) begin
      @(negedge clk);
      load_valid = 1'b1;
      load_req   = '{addr: BOOT_ADDR + 12'(i), data: {16'h0, prog[i]}};
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      @(negedge clk);
      load_valid = 1'b1;
      load_req   = '{addr: 12'(DATA_BASE + i), data: ref_mem[DATA_BASE + i]};
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    errors++;
    $display("ERR test %0d %s got %h expected %h", cur_test, name, got, exp);
  endtask

  task automatic check_exit_state();
    logic        exp_failed;
    logic [31:0] exp_exit_value;
    exp_failed     = exp_exited && (exp_value != 32'h0);
    exp_exit_value = exp_exited ? exp_value : 32'h0;
    checks++;
    if (tests_passed !== exp_passed) begin
      report_mismatch("tests_passed_o", tests_passed, exp_passed);
    end
    if (exit_valid !== exp_exited) begin
      report_mismatch("exit_valid_o", exit_valid, exp_exited);
    end
    if (tests_failed !== exp_failed) begin
      report_mismatch("tests_failed_o", tests_failed, exp_failed);
    end
    if (exit_value !== exp_exit_value) begin
      report_mismatch("exit_value_o", exit_value, exp_exit_value);
    end
  endtask

  // waits for the end of each run, then checks again once it has settled
  initial begin
    forever begin
      @(run_go);
      while (!(tests_passed || exit_valid)) begin
        @(negedge clk);
      end
      check_exit_state();
      repeat (SETTLE_CYCLES) @(negedge clk);
      check_exit_state();
      if (DUT.instr_req !== 1'b0) begin
        errors++;
        $display("test %0d: core kept fetching after the run ended", cur_test);
      end
      for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
        if (DUT.ram_i.mem_q[i] !== ref_mem[i]) begin
          report_mismatch($sformatf("mem_q[%0d]", i), DUT.ram_i.mem_q[i], ref_mem[i]);
        end
      end
      -> run_checked;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("checks %0d errors %0d", checks, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hefb87cda));
    reset        = 1'b1;
    fetch_enable = 1'b0;
    load_valid   = 1'b0;
    load_req     = '0;
    for (int unsigned t = 0; t < NUM_TESTS; t++) begin
      cur_test = t;
      apply_reset();
      build_test(t);
      load_memory();
      run_model(exp_passed, exp_exited, exp_value);
      @(negedge clk);
      fetch_enable = 1'b1;
      -> run_go;
      @(run_checked);
      @(negedge clk);
      fetch_enable = 1'b0;
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/subsys_pkg.sv
hdl/acc_core.sv
hdl/mul_copro.sv
hdl/mm_ram.sv
hdl/exit_regs.sv
hdl/tb_subsystem.sv
sim/clk_gen.sv
sim/tb_asserts.sv
sim/tb_top.sv
